// ==== logic/snn_geom_pkg.sv ====
`default_nettype none

package snn_geom_pkg;

    localparam int NUM_PIXELS    = 196;             // 14 x 14 input image
    localparam int NUM_NEURONS   = 10;              // one per output class
    localparam int PIX_IDX_W     = 8;
    localparam int NRN_IDX_W     = 4;
    localparam int DATA_W        = 8;               // pixels, weights, membranes, counts
    localparam int WEIGHT_ADDR_W = 11;              // 1960 weights, pixel * 10 + neuron
    localparam int FIFO_DEPTH    = 16;
    localparam int FIFO_PTR_W    = $clog2(FIFO_DEPTH);

    typedef logic [PIX_IDX_W-1:0] pix_idx_t;
    typedef logic [NRN_IDX_W-1:0] nrn_idx_t;
    typedef logic [DATA_W-1:0]    byte_t;

    // fibonacci lfsr, shifts left, feedback into bit 0
    localparam byte_t LFSR_SEED = 8'h5a;
    localparam byte_t LFSR_TAPS = 8'b1011_1000;     // bits 7, 5, 4, 3

endpackage

`default_nettype wire

// ==== logic/snn_regs_pkg.sv ====
`default_nettype none

package snn_regs_pkg;

    localparam int APB_ADDR_W  = 16;
    localparam int WORD_ADDR_W = APB_ADDR_W - 2;   // 32-bit words

    // control registers, word addresses (byte address >> 2)
    typedef enum logic [WORD_ADDR_W-1:0] {
        REG_BETA       = 14'h0000,  // leak factor, membrane * beta / 256
        REG_VTH        = 14'h0001,  // firing threshold
        REG_STEPS      = 14'h0002,  // timesteps per inference
        REG_START      = 14'h0003,  // any write kicks off an inference
        REG_STATUS     = 14'h0004,  // bit 0 busy, bit 1 done
        REG_COUNT_BASE = 14'h0008   // ten spike counts follow
    } reg_addr_e;

    // memory windows, byte addresses, one byte per word
    localparam logic [APB_ADDR_W-1:0] IMG_BASE = 16'h0400;
    localparam logic [APB_ADDR_W-1:0] WGT_BASE = 16'h1000;

endpackage

`default_nettype wire

// ==== logic/apb_regs.sv ====
`default_nettype none

module apb_regs
    import snn_geom_pkg::*;
    import snn_regs_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      psel_i,
    input  logic                      penable_i,
    input  logic                      pwrite_i,
    input  logic [APB_ADDR_W-1:0]     paddr_i,
    input  logic [31:0]               pwdata_i,
    output logic [31:0]               prdata_o,
    output logic                      pready_o,
    output logic                      pslverr_o,
    input  logic                      busy_i,
    input  logic                      done_i,
    output nrn_idx_t                  count_rd_idx_o,
    input  byte_t                     count_rd_data_i,
    output logic                      pix_we_o,
    output pix_idx_t                  pix_addr_o,
    output logic                      wgt_we_o,
    output logic [WEIGHT_ADDR_W-1:0]  wgt_addr_o,
    output byte_t                     wr_data_o,
    output byte_t                     beta_o,
    output byte_t                     vth_o,
    output byte_t                     steps_o,
    output logic                      start_o
);

    logic [WORD_ADDR_W-1:0] word;
    logic [WORD_ADDR_W-1:0] cnt_off;
    logic [APB_ADDR_W-1:0]  img_off;
    logic [APB_ADDR_W-1:0]  wgt_off;
    logic in_img, in_wgt, in_cnt, in_reg;
    logic access, wr_en;

    assign word    = paddr_i[APB_ADDR_W-1:2];
    assign img_off = paddr_i - IMG_BASE;            // wraps high below the window
    assign wgt_off = paddr_i - WGT_BASE;
    assign cnt_off = word - REG_COUNT_BASE;

    assign in_img = img_off[APB_ADDR_W-1:2] < NUM_PIXELS;
    assign in_wgt = wgt_off[APB_ADDR_W-1:2] < NUM_PIXELS * NUM_NEURONS;
    assign in_cnt = cnt_off < NUM_NEURONS;
    assign in_reg = word inside {REG_BETA, REG_VTH, REG_STEPS, REG_START, REG_STATUS};

    assign access    = psel_i && penable_i;
    assign pready_o  = 1'b1;                        // no wait states
    // unmapped address, or any write while an inference runs
    assign pslverr_o = access && (!(in_img || in_wgt || in_cnt || in_reg) ||
                                  (pwrite_i && busy_i));
    assign wr_en     = access && pwrite_i && !pslverr_o;

    // memory write steering
    assign pix_we_o   = wr_en && in_img;
    assign pix_addr_o = img_off[PIX_IDX_W+1:2];
    assign wgt_we_o   = wr_en && in_wgt;
    assign wgt_addr_o = wgt_off[WEIGHT_ADDR_W+1:2];
    assign wr_data_o  = pwdata_i[DATA_W-1:0];

    assign count_rd_idx_o = cnt_off[NRN_IDX_W-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            beta_o  <= '0;
            vth_o   <= '0;
            steps_o <= '0;
            start_o <= 1'b0;
        end else begin
            start_o <= wr_en && (word == REG_START);   // one-cycle pulse
            if (wr_en) begin
                case (word)
                    REG_BETA:  beta_o  <= wr_data_o;
                    REG_VTH:   vth_o   <= wr_data_o;
                    REG_STEPS: steps_o <= wr_data_o;
                    default: ;                       // status, counts read only
                endcase
            end
        end
    end

    // readback mux, memories are write only
    always_comb begin
        prdata_o = '0;
        if (in_cnt) begin
            prdata_o[DATA_W-1:0] = count_rd_data_i;
        end else begin
            case (word)
                REG_BETA:   prdata_o[DATA_W-1:0] = beta_o;
                REG_VTH:    prdata_o[DATA_W-1:0] = vth_o;
                REG_STEPS:  prdata_o[DATA_W-1:0] = steps_o;
                REG_STATUS: prdata_o[1:0]        = {done_i, busy_i};
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/timestep_ctrl.sv ====
`default_nettype none

module timestep_ctrl
    import snn_geom_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  start_i,
    input  byte_t steps_i,
    input  logic  encode_done_i,
    input  logic  fifo_empty_i,
    input  logic  fetch_idle_i,
    input  logic  leak_done_i,
    output logic  encode_start_o,
    output logic  leak_start_o,
    output logic  clear_o,
    output logic  busy_o,
    output logic  done_o
);

    typedef enum logic [2:0] {IDLE, ENCODE, DRAIN, LEAK, FINISH} ctrl_state_e;

    ctrl_state_e state;
    byte_t       step_cnt;      // timesteps completed

    assign busy_o = (state == ENCODE) || (state == DRAIN) || (state == LEAK);

    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= IDLE;
            step_cnt       <= '0;
            encode_start_o <= 1'b0;
            leak_start_o   <= 1'b0;
            clear_o        <= 1'b0;
            done_o         <= 1'b0;
        end else begin
            encode_start_o <= 1'b0;
            leak_start_o   <= 1'b0;
            clear_o        <= 1'b0;
            case (state)
                IDLE, FINISH: if (start_i) begin
                    clear_o  <= 1'b1;               // wipe membranes, counts, reseed
                    done_o   <= 1'b0;
                    step_cnt <= '0;
                    if (steps_i == '0) begin
                        state  <= FINISH;           // nothing to run
                        done_o <= 1'b1;
                    end else begin
                        state          <= ENCODE;
                        encode_start_o <= 1'b1;
                    end
                end
                ENCODE: if (encode_done_i) state <= DRAIN;
                // wait for queued spikes and in-flight weights
                DRAIN: if (fifo_empty_i && fetch_idle_i) begin
                    state        <= LEAK;
                    leak_start_o <= 1'b1;
                end
                LEAK: if (leak_done_i) begin
                    if (step_cnt == steps_i - 8'd1) begin
                        state  <= FINISH;
                        done_o <= 1'b1;             // held until next start
                    end else begin
                        step_cnt       <= step_cnt + 8'd1;
                        state          <= ENCODE;
                        encode_start_o <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/spike_encoder.sv ====
`default_nettype none

module spike_encoder
    import snn_geom_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     clear_i,
    input  logic     encode_start_i,
    input  logic     pix_we_i,
    input  pix_idx_t pix_addr_i,
    input  byte_t    pix_data_i,
    input  logic     fifo_full_i,
    output logic     push_o,
    output pix_idx_t push_idx_o,
    output logic     encode_done_o
);

    byte_t    pix_mem [NUM_PIXELS];   // image, written over apb
    byte_t    lfsr;
    byte_t    lfsr_next;
    pix_idx_t idx;                    // pixel under test
    logic     active;
    logic     hit;
    logic     advance;

    always_ff @(posedge clk) begin
        if (pix_we_i) pix_mem[pix_addr_i] <= pix_data_i;
    end

    assign lfsr_next  = {lfsr[DATA_W-2:0], ^(lfsr & LFSR_TAPS)};
    assign hit        = lfsr_next < pix_mem[idx];      // spike with prob pixel/256
    assign push_o     = active && hit;
    assign push_idx_o = idx;
    // hold push and index while the fifo is full
    assign advance    = active && !(hit && fifo_full_i);

    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr          <= LFSR_SEED;
            idx           <= '0;
            active        <= 1'b0;
            encode_done_o <= 1'b0;
        end else begin
            encode_done_o <= 1'b0;
            if (clear_i) lfsr <= LFSR_SEED;
            else if (advance) lfsr <= lfsr_next;    // one step per pixel examined
            if (encode_start_i) begin
                active <= 1'b1;
                idx    <= '0;
            end else if (advance) begin
                idx <= idx + 1'b1;
                if (idx == pix_idx_t'(NUM_PIXELS - 1)) begin
                    active        <= 1'b0;
                    encode_done_o <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/spike_fifo.sv ====
`default_nettype none

module spike_fifo
    import snn_geom_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     push_i,
    input  pix_idx_t push_idx_i,
    input  logic     pop_i,
    output logic     full_o,
    output logic     empty_o,
    output pix_idx_t head_o
);

    pix_idx_t              mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr, rd_ptr;
    logic [FIFO_PTR_W:0]   count;                 // occupancy, 0..depth
    logic                  do_push, do_pop;

    assign full_o  = count == FIFO_DEPTH;
    assign empty_o = count == '0;
    assign head_o  = mem[rd_ptr];
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= push_idx_i;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            count <= count + do_push - do_pop;
        end
    end

endmodule

`default_nettype wire

// ==== logic/synapse_fetch.sv ====
`default_nettype none

module synapse_fetch
    import snn_geom_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     wgt_we_i,
    input  logic [WEIGHT_ADDR_W-1:0] wgt_addr_i,
    input  byte_t                    wgt_data_i,
    input  logic                     fifo_empty_i,
    input  pix_idx_t                 head_i,
    output logic                     pop_o,
    output logic                     idle_o,
    output logic                     integ_valid_o,
    output nrn_idx_t                 integ_idx_o,
    output byte_t                    integ_weight_o
);

    byte_t                    wgt_mem [NUM_PIXELS * NUM_NEURONS];
    logic [WEIGHT_ADDR_W-1:0] base;       // pixel * 10
    logic [WEIGHT_ADDR_W-1:0] rd_addr;
    nrn_idx_t                 nrn;        // neuron being addressed
    logic                     walking;
    logic                     last;

    assign last    = nrn == nrn_idx_t'(NUM_NEURONS - 1);
    assign rd_addr = base + WEIGHT_ADDR_W'(nrn);
    // next spike may start on the last address cycle, keeps integrates back to back
    assign pop_o   = !fifo_empty_i && (!walking || last);
    assign idle_o  = !walking && !integ_valid_o;

    always_ff @(posedge clk) begin
        if (wgt_we_i) wgt_mem[wgt_addr_i] <= wgt_data_i;
        integ_weight_o <= wgt_mem[rd_addr];     // registered read
        integ_idx_o    <= nrn;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            walking       <= 1'b0;
            nrn           <= '0;
            base          <= '0;
            integ_valid_o <= 1'b0;
        end else begin
            integ_valid_o <= walking;           // lines up with read data
            if (pop_o) begin
                walking <= 1'b1;
                nrn     <= '0;
                base    <= WEIGHT_ADDR_W'(head_i) * WEIGHT_ADDR_W'(NUM_NEURONS);
            end else if (walking) begin
                nrn <= nrn + 1'b1;
                if (last) walking <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/neuron_array.sv ====
`default_nettype none

module neuron_array
    import snn_geom_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     clear_i,
    input  logic     integ_valid_i,
    input  nrn_idx_t integ_idx_i,
    input  byte_t    integ_weight_i,
    input  logic     leak_start_i,
    input  byte_t    beta_i,
    input  byte_t    vth_i,
    output logic     leak_done_o,
    input  nrn_idx_t count_rd_idx_i,
    output byte_t    count_rd_data_o
);

    byte_t                   membrane [NUM_NEURONS];
    byte_t                   count    [NUM_NEURONS];
    logic signed [DATA_W+1:0] sum;               // unsigned membrane + signed weight
    byte_t                   sat;
    logic [2*DATA_W-1:0]     prod;
    byte_t                   leaked;
    logic                    fire;
    nrn_idx_t                lk_idx;
    logic                    leaking;

    // integrate, clamp to 0..255
    assign sum = $signed({2'b00, membrane[integ_idx_i]}) + $signed(integ_weight_i);
    always_comb begin
        if (sum < 0) sat = '0;
        else if (sum > 255) sat = '1;
        else sat = sum[DATA_W-1:0];
    end

    // leak is membrane * beta / 256
    assign prod   = membrane[lk_idx] * beta_i;
    assign leaked = prod[2*DATA_W-1:DATA_W];
    assign fire   = leaked >= vth_i;

    assign count_rd_data_o = (count_rd_idx_i < NUM_NEURONS) ? count[count_rd_idx_i] : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            membrane    <= '{default: '0};
            count       <= '{default: '0};
            lk_idx      <= '0;
            leaking     <= 1'b0;
            leak_done_o <= 1'b0;
        end else begin
            leak_done_o <= 1'b0;
            if (clear_i) begin
                membrane <= '{default: '0};
                count    <= '{default: '0};
            end else if (integ_valid_i) begin
                membrane[integ_idx_i] <= sat;
            end else if (leaking) begin
                if (fire) begin
                    membrane[lk_idx] <= '0;         // reset on spike
                    count[lk_idx]    <= count[lk_idx] + 1'b1;
                end else begin
                    membrane[lk_idx] <= leaked;
                end
            end
            if (leak_start_i) begin
                leaking <= 1'b1;
                lk_idx  <= '0;
            end else if (leaking) begin
                lk_idx <= lk_idx + 1'b1;            // one neuron per cycle
                if (lk_idx == nrn_idx_t'(NUM_NEURONS - 1)) begin
                    leaking     <= 1'b0;
                    leak_done_o <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/snn_core.sv ====
`default_nettype none

module snn_core
    import snn_geom_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        psel_i,
    input  logic        penable_i,
    input  logic        pwrite_i,
    input  logic [15:0] paddr_i,
    input  logic [31:0] pwdata_i,
    output logic [31:0] prdata_o,
    output logic        pready_o,
    output logic        pslverr_o
);

    logic busy, done, start, clear, encode_start, encode_done, leak_start, leak_done;
    logic pix_we, wgt_we, push, full, empty, pop, fetch_idle, integ_valid;
    pix_idx_t pix_addr, push_idx, head;
    logic [WEIGHT_ADDR_W-1:0] wgt_addr;
    byte_t wr_data, beta, vth, steps, count_rd_data, integ_weight;
    nrn_idx_t count_rd_idx, integ_idx;

    apb_regs i_regs (
        .clk, .rst, .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
        .prdata_o, .pready_o, .pslverr_o, .busy_i(busy), .done_i(done),
        .count_rd_idx_o(count_rd_idx), .count_rd_data_i(count_rd_data),
        .pix_we_o(pix_we), .pix_addr_o(pix_addr), .wgt_we_o(wgt_we),
        .wgt_addr_o(wgt_addr), .wr_data_o(wr_data), .beta_o(beta), .vth_o(vth),
        .steps_o(steps), .start_o(start)
    );

    timestep_ctrl i_ctrl (
        .clk, .rst, .start_i(start), .steps_i(steps), .encode_done_i(encode_done),
        .fifo_empty_i(empty), .fetch_idle_i(fetch_idle), .leak_done_i(leak_done),
        .encode_start_o(encode_start), .leak_start_o(leak_start), .clear_o(clear),
        .busy_o(busy), .done_o(done)
    );

    spike_encoder i_encoder (
        .clk, .rst, .clear_i(clear), .encode_start_i(encode_start), .pix_we_i(pix_we),
        .pix_addr_i(pix_addr), .pix_data_i(wr_data), .fifo_full_i(full),
        .push_o(push), .push_idx_o(push_idx), .encode_done_o(encode_done)
    );

    spike_fifo i_fifo (
        .clk, .rst, .push_i(push), .push_idx_i(push_idx), .pop_i(pop),
        .full_o(full), .empty_o(empty), .head_o(head)
    );

    synapse_fetch i_fetch (
        .clk, .rst, .wgt_we_i(wgt_we), .wgt_addr_i(wgt_addr), .wgt_data_i(wr_data),
        .fifo_empty_i(empty), .head_i(head), .pop_o(pop), .idle_o(fetch_idle),
        .integ_valid_o(integ_valid), .integ_idx_o(integ_idx),
        .integ_weight_o(integ_weight)
    );

    neuron_array i_neurons (
        .clk, .rst, .clear_i(clear), .integ_valid_i(integ_valid), .integ_idx_i(integ_idx),
        .integ_weight_i(integ_weight), .leak_start_i(leak_start), .beta_i(beta),
        .vth_i(vth), .leak_done_o(leak_done), .count_rd_idx_i(count_rd_idx),
        .count_rd_data_o(count_rd_data)
    );

endmodule

`default_nettype wire

// ==== tests/snn_model.svh ====
`ifndef SNN_MODEL_SVH
`define SNN_MODEL_SVH

byte_t m_img [NUM_PIXELS];                 // image as written over apb
byte_t m_wgt [NUM_PIXELS * NUM_NEURONS];   // pixel * 10 + neuron
byte_t m_cnt [NUM_NEURONS];                // predicted spike counts

// 8-bit fibonacci step, taps 7 5 4 3, shifts left
function automatic byte_t enc_lfsr_step(input byte_t s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
endfunction

// unsigned membrane plus signed weight, clamped to 0..255
function automatic byte_t clamp_add(input byte_t mem, input byte_t w);
    logic signed [7:0] ws;
    int                s;
    ws = w;
    s  = int'(mem) + ws;
    if (s < 0) return 8'h00;
    if (s > 255) return 8'hff;
    return byte_t'(s);
endfunction

task automatic predict_counts(input byte_t beta, input byte_t vth, input int steps);
    byte_t lfsr;
    byte_t mem [NUM_NEURONS];
    byte_t lk;
    lfsr = LFSR_SEED;                      // reseeded once per inference
    for (int n = 0; n < NUM_NEURONS; n++) begin
        mem[n]   = 8'h00;
        m_cnt[n] = 8'h00;
    end
    for (int t = 0; t < steps; t++) begin
        for (int p = 0; p < NUM_PIXELS; p++) begin
            lfsr = enc_lfsr_step(lfsr);    // one step per pixel
            if (lfsr < m_img[p]) begin
                for (int n = 0; n < NUM_NEURONS; n++)
                    mem[n] = clamp_add(mem[n], m_wgt[p * NUM_NEURONS + n]);
            end
        end
        for (int n = 0; n < NUM_NEURONS; n++) begin
            lk = byte_t'((int'(mem[n]) * int'(beta)) >> 8);   // leak by beta / 256
            if (lk >= vth) begin
                mem[n]   = 8'h00;          // fire and reset
                m_cnt[n] = m_cnt[n] + 8'd1;
            end else begin
                mem[n] = lk;
            end
        end
    end
endtask

`endif

// ==== tests/tb_snn_core.sv ====
`default_nettype none

module tb_snn_core
    import snn_geom_pkg::*;
    import snn_regs_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    logic        clk = 1'b0;
    logic        rst;
    logic        psel, penable, pwrite;
    logic [15:0] paddr;
    logic [31:0] pwdata, prdata;
    logic        pready, pslverr;

    logic [31:0] rng = 32'h4e29;     // stimulus lfsr state
    logic [31:0] rdata;              // data of the last transfer
    byte_t       cfg_beta, cfg_vth, cfg_steps;
    int          errors = 0;
    int          err_base = 0;       // errors before the current test
    int          tests_run = 0;
    int          tests_failed = 0;

    `include "snn_model.svh"

    snn_core i_dut (
        .clk, .rst, .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
        .paddr_i(paddr), .pwdata_i(pwdata), .prdata_o(prdata), .pready_o(pready),
        .pslverr_o(pslverr)
    );

    always #4 clk = ~clk;            // 8 ns period

    // 32-bit fibonacci with taps 32 22 2 1 and one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb  = rng[31] ^ rng[21] ^ rng[1] ^ rng[0];
            rng = {rng[30:0], fb};
            r   = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [15:0] byte_addr(input int word);
        return 16'(word * 4);
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $finish;
    endtask

    // one apb transfer with setup then access phase
    task automatic transfer(input logic wr, input logic [15:0] addr, input logic [31:0] data,
                            input logic exp_err);
        int waited;
        waited = 0;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);              // outputs settled mid access phase
        while (pready !== 1'b1 && waited < 16) begin
            @(negedge clk);
            waited++;
        end
        if (pready !== 1'b1) begin
            abort_run("pready stayed low in the access phase");
        end else begin
            if (pslverr !== exp_err) begin
                $display("** Error pslverr at %h: got %h expected %h", addr, pslverr, exp_err);
                errors++;
            end
            rdata = prdata;
            @(posedge clk);          // transfer completes here
            psel    <= 1'b0;
            penable <= 1'b0;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == err_base) begin
            $display("%s: pass", name);
        end else begin
            $display("%s: fail, %0d errors", name, errors - err_base);
            tests_failed++;
        end
        err_base = errors;
    endtask

    // mode 0 random, 1 all zero, otherwise all 255
    task automatic load_image(input int mode);
        for (int p = 0; p < NUM_PIXELS; p++) begin
            case (mode)
                0: m_img[p] = 8'(rand_bits(8));
                1: m_img[p] = 8'h00;
                default: m_img[p] = 8'hff;
            endcase
            transfer(1'b1, IMG_BASE + 16'(4 * p), 32'(m_img[p]), 1'b0);
        end
    endtask

    task automatic load_weights(input logic saturate);
        for (int a = 0; a < NUM_PIXELS * NUM_NEURONS; a++) begin
            if (saturate) m_wgt[a] = ((a % NUM_NEURONS) % 2 == 0) ? 8'h7f : 8'h80;
            else m_wgt[a] = 8'(rand_bits(8));
            transfer(1'b1, WGT_BASE + 16'(4 * a), 32'(m_wgt[a]), 1'b0);
        end
    endtask

    task automatic configure(input byte_t beta, input byte_t vth, input byte_t steps);
        cfg_beta  = beta;
        cfg_vth   = vth;
        cfg_steps = steps;
        transfer(1'b1, byte_addr(REG_BETA), 32'(beta), 1'b0);
        transfer(1'b1, byte_addr(REG_VTH), 32'(vth), 1'b0);
        transfer(1'b1, byte_addr(REG_STEPS), 32'(steps), 1'b0);
    endtask

    // poll status until done within a bounded number of reads
    task automatic wait_done();
        int polls;
        polls = 0;
        rdata = '0;
        while (rdata[1] !== 1'b1 && polls < 20000) begin
            transfer(1'b0, byte_addr(REG_STATUS), '0, 1'b0);
            polls++;
        end
        if (rdata[1] !== 1'b1) abort_run("timeout, done never rose");
    endtask

    task automatic check_run(input string name, input logic zero_only);
        byte_t exp;
        wait_done();
        predict_counts(cfg_beta, cfg_vth, int'(cfg_steps));
        for (int n = 0; n < NUM_NEURONS; n++) begin
            exp = zero_only ? 8'h00 : m_cnt[n];
            transfer(1'b0, byte_addr(REG_COUNT_BASE + n), '0, 1'b0);
            if (rdata[7:0] !== exp) begin
                $display("** Error count[%0d]: got %h expected %h", n, rdata[7:0], exp);
                errors++;
            end
        end
        finish_test(name);
    endtask

    initial begin
        rst     <= 1'b1;
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= '0;
        pwdata  <= '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        configure(8'hc8, 8'h40, 8'd3);
        transfer(1'b0, byte_addr(REG_BETA), '0, 1'b0);
        check_value("beta", rdata, 32'hc8);
        transfer(1'b0, byte_addr(REG_VTH), '0, 1'b0);
        check_value("vth", rdata, 32'h40);
        transfer(1'b0, byte_addr(REG_STEPS), '0, 1'b0);
        check_value("steps", rdata, 32'h3);
        transfer(1'b0, byte_addr(REG_STATUS), '0, 1'b0);
        check_value("status", rdata, 32'h0);       // idle, not done
        transfer(1'b0, 16'h0014, '0, 1'b1);        // hole in register space
        transfer(1'b1, 16'h8000, 32'h1, 1'b1);     // past the weight window
        finish_test("register readback");

        load_image(0);
        load_weights(1'b0);
        configure(8'(rand_bits(8)), 8'(rand_bits(8)), 8'd1 + 8'(rand_bits(3)));
        transfer(1'b1, byte_addr(REG_START), 32'h1, 1'b0);
        check_run("full inference", 1'b0);

        load_image(1);                             // weights kept
        configure(8'(rand_bits(8)), 8'd1 + 8'(rand_bits(7)), 8'd1 + 8'(rand_bits(3)));
        transfer(1'b1, byte_addr(REG_START), 32'h1, 1'b0);
        check_run("silent image", 1'b1);

        load_image(2);                             // nearly every pixel spikes
        load_weights(1'b1);
        // low threshold so a wrapped negative membrane would fire
        configure(8'hf0, 8'h40, 8'd3);
        transfer(1'b1, byte_addr(REG_START), 32'h1, 1'b0);
        check_run("saturating weights", 1'b0);

        load_image(0);
        load_weights(1'b0);
        configure(8'(rand_bits(8)), 8'(rand_bits(8)), 8'd1 + 8'(rand_bits(3)));
        transfer(1'b1, byte_addr(REG_START), 32'h1, 1'b0);
        transfer(1'b1, byte_addr(REG_BETA), 32'(~cfg_beta), 1'b1);   // must be dropped
        transfer(1'b1, IMG_BASE, 32'hff, 1'b1);
        transfer(1'b0, byte_addr(REG_STATUS), '0, 1'b0);
        check_value("status.busy", 32'(rdata[0]), 32'h1);
        transfer(1'b0, byte_addr(REG_BETA), '0, 1'b0);
        check_value("beta", rdata, 32'(cfg_beta));
        check_run("busy write rejection", 1'b0);

        configure(cfg_beta, cfg_vth, 8'd1 + 8'(rand_bits(3)));
        transfer(1'b1, byte_addr(REG_START), 32'h1, 1'b0);
        check_run("back-to-back run", 1'b0);

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) $display("TEST PASSED");
        else $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== snn_core.f ====
+incdir+tests
logic/snn_geom_pkg.sv
logic/snn_regs_pkg.sv
logic/apb_regs.sv
logic/timestep_ctrl.sv
logic/spike_encoder.sv
logic/spike_fifo.sv
logic/synapse_fetch.sv
logic/neuron_array.sv
logic/snn_core.sv
tests/tb_snn_core.sv

// ==== Bender.yml ====
package:
  name: snn_core

sources:
  - logic/snn_geom_pkg.sv
  - logic/snn_regs_pkg.sv
  - logic/apb_regs.sv
  - logic/timestep_ctrl.sv
  - logic/spike_encoder.sv
  - logic/spike_fifo.sv
  - logic/synapse_fetch.sv
  - logic/neuron_array.sv
  - logic/snn_core.sv
  - target: simulation
    include_dirs:
      - tests
    files:
      - tests/tb_snn_core.sv
